// File: run_sim.sh
#!/bin/sh
# build and run the zx_pager testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f zx_pager.f \
	--top-module tb_zx_pager -o sim_zx_pager
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench can count them
out=$(./obj_dir/sim_zx_pager +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1

// File: src/dos_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dos_ctrl import zx_pager_pkg::*;
(
	input  logic               fclk,
	input  logic               reset,
	input  logic [NUM_WIN-1:0] dos_on,
	input  logic [NUM_WIN-1:0] dos_off,
	input  logic               cpm_n,
	output logic               dos
);

	logic dos_q;

	// on and off never come from the same fetch
	always_ff @(posedge fclk)
	begin
		if (reset)
			dos_q <= 1'b0;
		else if (|dos_on)
			dos_q <= 1'b1;
		else if (|dos_off)
			dos_q <= 1'b0;
	end

	// cp/m mode pins the dos rom in
	assign dos = dos_q | ~cpm_n;

endmodule

`default_nettype wire

// File: src/mem_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module mem_mapper import zx_pager_pkg::*;
(
	input  logic     fclk,
	input  logic     reset,
	input  z_bus_t   bus,
	input  win_map_t win_map [NUM_WIN],
	output mem_req_t mem
);

	logic     acc;
	win_map_t sel;
	logic     valid_q;
	logic     rom_q;
	logic     ram_q;
	page_t    page_q;
	offset_t  offset_q;

	assign acc = bus.mreq & (bus.rd | bus.wr);
	assign sel = win_map[bus.addr[15:14]];

	// chip selects
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			valid_q <= 1'b0;
			rom_q   <= 1'b0;
			ram_q   <= 1'b0;
		end
		else
		begin
			valid_q <= acc;
			rom_q   <= acc & ~sel.ram_sel;
			ram_q   <= acc & sel.ram_sel;
		end
	end

	// physical address
	always_ff @(posedge fclk)
	begin
		if (acc)
		begin
			page_q   <= sel.page;
			offset_q <= bus.addr[13:0];
		end
	end

	assign mem.valid  = valid_q;
	assign mem.rom_cs = rom_q;
	assign mem.ram_cs = ram_q;
	assign mem.page   = page_q;
	assign mem.offset = offset_q;

endmodule

`default_nettype wire

// File: src/reset_stretch.sv
`timescale 1ns/1ps
`default_nettype none

module reset_stretch import zx_pager_pkg::*;
(
	input  logic fclk,
	input  logic reset,
	input  logic soft_rst,
	output logic sys_reset
);

	logic [RST_CNT_SIZE-1:0] cnt;
	logic                    stretch;

	// counter restarts on either reset source and stops when full
	always_ff @(posedge fclk)
	begin
		if (reset || soft_rst)
		begin
			cnt     <= '0;
			stretch <= 1'b1;
		end
		else
		begin
			if (cnt != '1)
				cnt <= cnt + 1'b1;
			stretch <= (cnt != '1);
		end
	end

	// external reset passes straight through, the counter adds the tail
	assign sys_reset = reset | stretch;

endmodule

`default_nettype wire

// File: src/window_pager.sv
`timescale 1ns/1ps
`default_nettype none

module window_pager import zx_pager_pkg::*;
#(
	parameter int WIN = 0
)
(
	input  logic       fclk,
	input  logic       reset,
	input  z_bus_t     bus,
	input  pager_cfg_t pcfg,
	input  logic       dos,
	output win_map_t   map,
	output logic       dos_on,
	output logic       dos_off
);

	data_t     page_reg;
	win_map_t  pent_map;
	rom_page_t rom_pg;
	logic      m1_fetch;
	logic      in_win;

	// reset value selects rom page 0
	always_ff @(posedge fclk)
	begin
		if (reset)
			page_reg <= '0;
		else if (pcfg.page_wr && (pcfg.page_wr_win == win_idx_t'(WIN)))
			page_reg <= pcfg.page_wr_data;
	end

	//////////////////////////////
	// pentagon 128k layout
	//////////////////////////////

	assign rom_pg = {dos, pcfg.rom48_sel};

	always_comb
	begin
		case (WIN)
			0:
			begin
				pent_map.ram_sel = 1'b0;
				pent_map.page    = page_t'(rom_pg);
			end
			1:
			begin
				pent_map.ram_sel = 1'b1;
				pent_map.page    = 6'd5;
			end
			2:
			begin
				pent_map.ram_sel = 1'b1;
				pent_map.page    = 6'd2;
			end
			default:
			begin
				pent_map.ram_sel = 1'b1;
				pent_map.page    = page_t'(pcfg.ram3_page);
			end
		endcase
	end

	// pager mode, rom windows keep only 64k worth of page
	always_comb
	begin
		if (pcfg.pager_en)
		begin
			map.ram_sel = page_reg[PAGE_RAM_BIT];
			if (page_reg[PAGE_RAM_BIT])
				map.page = page_reg[5:0];
			else
				map.page = page_t'(page_reg[1:0]);
		end
		else
			map = pent_map;
	end

	//////////////////////////////
	// dos entry and exit
	//////////////////////////////

	assign m1_fetch = bus.mreq & bus.rd & bus.m1;
	assign in_win   = (bus.addr[15:14] == win_idx_t'(WIN));

	// entry only from the 48k basic rom in window 0
	assign dos_on = (WIN == 0) && m1_fetch && in_win && !map.ram_sel
		&& pcfg.rom48_sel && (bus.addr[15:8] == DOS_ENTRY_HI);

	assign dos_off = m1_fetch & in_win & map.ram_sel;

endmodule

`default_nettype wire

// File: src/z_ports.sv
`timescale 1ns/1ps
`default_nettype none

module z_ports import zx_pager_pkg::*;
(
	input  logic       fclk,
	input  logic       reset,
	input  z_bus_t     bus,
	input  win_map_t   win_map [NUM_WIN],
	output pager_cfg_t pcfg,
	output logic       cpm_n,
	output logic       soft_rst,
	output logic       beep,
	output data_t      rd_data,
	output logic       rd_valid
);

	logic       io_wr;
	logic       io_rd;
	data_t      port_lo;
	logic       wr_7ffd;
	logic       wr_cfg;
	logic       wr_page;
	logic       wr_fe;
	logic       lock_7ffd;
	logic       pager_en;
	logic       rom48_sel;
	logic [2:0] ram3_page;
	win_map_t   rd_map;

	//////////////////////////////
	// decode
	//////////////////////////////

	assign io_wr   = bus.iorq & bus.wr;
	assign io_rd   = bus.iorq & bus.rd;
	assign port_lo = bus.addr[7:0];

	// 7ffd is the only fully decoded port
	assign wr_7ffd = io_wr && (bus.addr == PORT_7FFD);
	assign wr_cfg  = io_wr && (port_lo == PORT_CFG_LO);
	assign wr_page = io_wr && (port_lo == PORT_PAGE_LO);
	assign wr_fe   = io_wr && (port_lo == PORT_FE_LO);

	assign soft_rst = io_wr && (port_lo == PORT_SRST_LO) && (bus.wdata == SRST_KEY);

	//////////////////////////////
	// registers
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			lock_7ffd <= 1'b0;
			rom48_sel <= 1'b0;
			ram3_page <= 3'd0;
		end
		else if (wr_7ffd && !lock_7ffd)
		begin
			ram3_page <= bus.wdata[2:0];
			rom48_sel <= bus.wdata[4];
			lock_7ffd <= bus.wdata[5];
		end
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pager_en <= 1'b0;
			cpm_n    <= 1'b1;
		end
		else if (wr_cfg)
		begin
			pager_en <= bus.wdata[0];
			cpm_n    <= bus.wdata[1];
		end
	end

	// beeper bit only, no sound path here
	always_ff @(posedge fclk)
	begin
		if (reset)
			beep <= 1'b0;
		else if (wr_fe)
			beep <= bus.wdata[4];
	end

	// page writes go to the pagers in the same cycle
	assign pcfg.pager_en     = pager_en;
	assign pcfg.rom48_sel    = rom48_sel;
	assign pcfg.ram3_page    = ram3_page;
	assign pcfg.page_wr      = wr_page;
	assign pcfg.page_wr_win  = bus.addr[15:14];
	assign pcfg.page_wr_data = bus.wdata;

	//////////////////////////////
	// readback
	//////////////////////////////

	assign rd_map = win_map[bus.addr[15:14]];

	always_ff @(posedge fclk)
	begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= io_rd;
	end

	// unknown ports float high, like an idle bus
	always_ff @(posedge fclk)
	begin
		if (io_rd)
		begin
			if (port_lo == PORT_RDBK_LO)
				rd_data <= {rd_map.ram_sel, 1'b0, rd_map.page};
			else
				rd_data <= 8'hFF;
		end
	end

endmodule

`default_nettype wire

// File: src/zx_pager_pkg.sv
`default_nettype none

package zx_pager_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [5:0]  page_t;
	typedef logic [1:0]  rom_page_t;
	typedef logic [13:0] offset_t;
	typedef logic [1:0]  win_idx_t;

	//////////////////////////////
	// constants
	//////////////////////////////

	localparam int NUM_WIN = 4;

	// i/o port addresses
	localparam addr_t PORT_7FFD    = 16'h7FFD;
	localparam data_t PORT_CFG_LO  = 8'h77;
	localparam data_t PORT_PAGE_LO = 8'hF7;
	localparam data_t PORT_RDBK_LO = 8'hBE;
	localparam data_t PORT_FE_LO   = 8'hFE;
	localparam data_t PORT_SRST_LO = 8'hBF;

	// magic byte for software reset
	localparam data_t SRST_KEY = 8'hA5;

	localparam int RST_CNT_SIZE = 6;

	// high byte of the trdos entry points
	localparam data_t DOS_ENTRY_HI = 8'h3D;

	localparam int PAGE_RAM_BIT = 7;

	//////////////////////////////
	// bundles
	//////////////////////////////

	// one-cycle strobes, synchronous to fclk
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  mreq;
		logic  iorq;
		logic  rd;
		logic  wr;
		logic  m1;
	} z_bus_t;

	typedef struct packed {
		logic  ram_sel;
		page_t page;
	} win_map_t;

	typedef struct packed {
		logic       pager_en;
		logic       rom48_sel;
		logic [2:0] ram3_page;
		logic       page_wr;
		win_idx_t   page_wr_win;
		data_t      page_wr_data;
	} pager_cfg_t;

	typedef struct packed {
		logic    valid;
		logic    rom_cs;
		logic    ram_cs;
		page_t   page;
		offset_t offset;
	} mem_req_t;

endpackage

`default_nettype wire

// File: src/zx_pager_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_pager_top import zx_pager_pkg::*;
(
	input  logic     fclk,
	input  logic     reset,
	input  z_bus_t   bus,
	output mem_req_t mem,
	output data_t    rd_data,
	output logic     rd_valid,
	output logic     dos,
	output logic     beep,
	output logic     cpu_reset
);

	logic               sys_reset;
	logic               soft_rst;
	logic               cpm_n;
	pager_cfg_t         pcfg;
	win_map_t           win_map [NUM_WIN];
	logic [NUM_WIN-1:0] dos_on;
	logic [NUM_WIN-1:0] dos_off;

	reset_stretch u_reset_stretch (
		.fclk      (fclk),
		.reset     (reset),
		.soft_rst  (soft_rst),
		.sys_reset (sys_reset)
	);

	// cpu sees the stretched reset as is
	assign cpu_reset = sys_reset;

	z_ports u_z_ports (
		.fclk     (fclk),
		.reset    (sys_reset),
		.bus      (bus),
		.win_map  (win_map),
		.pcfg     (pcfg),
		.cpm_n    (cpm_n),
		.soft_rst (soft_rst),
		.beep     (beep),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	//////////////////////////////
	// one pager per 16k window
	//////////////////////////////

	for (genvar i = 0; i < NUM_WIN; i++)
	begin : g_win
		window_pager #(
			.WIN (i)
		) u_window_pager (
			.fclk    (fclk),
			.reset   (sys_reset),
			.bus     (bus),
			.pcfg    (pcfg),
			.dos     (dos),
			.map     (win_map[i]),
			.dos_on  (dos_on[i]),
			.dos_off (dos_off[i])
		);
	end

	dos_ctrl u_dos_ctrl (
		.fclk    (fclk),
		.reset   (sys_reset),
		.dos_on  (dos_on),
		.dos_off (dos_off),
		.cpm_n   (cpm_n),
		.dos     (dos)
	);

	mem_mapper u_mem_mapper (
		.fclk    (fclk),
		.reset   (sys_reset),
		.bus     (bus),
		.win_map (win_map),
		.mem     (mem)
	);

endmodule

`default_nettype wire

// File: tb/tb_zx_pager.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_pager import zx_pager_pkg::*;
();

	localparam logic [15:0] LFSR_SEED      = 16'd3021;
	localparam int          TIMEOUT_CYCLES = 3000;

	logic        fclk;
	logic        reset;
	z_bus_t      bus;
	mem_req_t    mem;
	data_t       rd_data;
	logic        rd_valid;
	logic        dos;
	logic        beep;
	logic        cpu_reset;
	logic [15:0] lfsr;
	int          cycle_cnt = 0;
	int          tb_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          errs_at_start = 0;

	zx_pager_top u_zx_pager_top (
		.fclk      (fclk),
		.reset     (reset),
		.bus       (bus),
		.mem       (mem),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.dos       (dos),
		.beep      (beep),
		.cpu_reset (cpu_reset)
	);

	always #20 fclk = ~fclk;

	always @(posedge fclk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("run stopped, tests still busy after %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[14:0], lfsr[0]};
		end
	endtask

	function automatic int error_total();
		return tb_errs + u_zx_pager_top.u_zx_pager_assert.fail_cnt;
	endfunction

	task automatic mem_access(input addr_t a, input logic wr, input logic m1);
		@(negedge fclk);
		bus.addr = a;
		bus.mreq = 1'b1;
		bus.rd   = ~wr;
		bus.wr   = wr;
		bus.m1   = m1 & ~wr;
		@(negedge fclk);
		bus = '0;
	endtask

	task automatic io_write(input addr_t a, input data_t d);
		@(negedge fclk);
		bus.addr  = a;
		bus.wdata = d;
		bus.iorq  = 1'b1;
		bus.wr    = 1'b1;
		@(negedge fclk);
		bus = '0;
	endtask

	task automatic io_read(input addr_t a);
		@(negedge fclk);
		bus.addr = a;
		bus.iorq = 1'b1;
		bus.rd   = 1'b1;
		@(negedge fclk);
		bus = '0;
	endtask

	task automatic random_access(input int w);
		logic [15:0] r;
		take_bits(15, r);
		mem_access({win_idx_t'(w), r[13:0]}, r[14], 1'b0);
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (cpu_reset && (n < 200))
		begin
			@(negedge fclk);
			n++;
		end
		if (cpu_reset)
		begin
			$display("cpu_reset did not fall within 200 cycles");
			tb_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		repeat (2) @(negedge fclk);
		tests_run++;
		if (error_total() == errs_at_start)
			$display("test %0d %s: pass", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: FAIL, %0d errors", tests_run, name,
				error_total() - errs_at_start);
		end
		errs_at_start = error_total();
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	initial
	begin
		logic [15:0] r;
		fclk  = 1'b0;
		reset = 1'b1;
		bus   = '0;
		lfsr  = LFSR_SEED;

		repeat (10) @(negedge fclk);
		reset = 1'b0;
		wait_reset_release();
		finish_test("reset stretch");

		// pentagon layout, then 7ffd until the lock bit
		for (int w = 0; w < NUM_WIN; w++)
			repeat (4) random_access(w);
		repeat (3)
		begin
			take_bits(8, r);
			io_write(PORT_7FFD, r[7:0] & 8'hDF);
			random_access(0);
			random_access(3);
		end
		take_bits(8, r);
		io_write(PORT_7FFD, r[7:0] | 8'h30);
		take_bits(8, r);
		io_write(PORT_7FFD, r[7:0] & 8'hCF);
		random_access(0);
		random_access(3);
		finish_test("pentagon mapping");

		io_write({8'h00, PORT_CFG_LO}, 8'h03);
		repeat (3)
		begin
			for (int w = 0; w < NUM_WIN; w++)
			begin
				take_bits(8, r);
				io_write({win_idx_t'(w), 6'd0, PORT_PAGE_LO}, r[7:0]);
				random_access(w);
				io_read({win_idx_t'(w), 6'd0, PORT_RDBK_LO});
			end
		end
		io_read(16'h001F);
		io_read(PORT_7FFD);
		io_read(16'hFFDF);
		finish_test("page registers");

		// rom48 stays selected from the locked 7ffd
		io_write({8'h00, PORT_CFG_LO}, 8'h02);
		take_bits(8, r);
		mem_access({DOS_ENTRY_HI, r[7:0]}, 1'b0, 1'b1);
		mem_access(16'h0100, 1'b0, 1'b1);
		mem_access(16'h4123, 1'b0, 1'b1);
		mem_access({DOS_ENTRY_HI, 8'h13}, 1'b0, 1'b1);
		io_write({8'h00, PORT_CFG_LO}, 8'h00);
		mem_access(16'h8000, 1'b0, 1'b1);
		random_access(0);
		io_write({8'h00, PORT_CFG_LO}, 8'h02);
		mem_access({DOS_ENTRY_HI, 8'h2F}, 1'b0, 1'b1);
		mem_access(16'hC010, 1'b0, 1'b1);
		finish_test("dos flag");

		io_write({8'h00, PORT_FE_LO}, 8'h10);
		io_write({8'h00, PORT_FE_LO}, 8'h00);
		take_bits(8, r);
		io_write({8'h00, PORT_FE_LO}, r[7:0] | 8'h10);
		io_write({8'h00, PORT_SRST_LO}, 8'h5A);
		io_write({8'h00, PORT_SRST_LO}, SRST_KEY);
		wait_reset_release();
		for (int w = 0; w < NUM_WIN; w++)
			random_access(w);
		io_write(PORT_7FFD, 8'h07);
		random_access(3);
		// 3dxx in the 128k rom leaves dos off
		mem_access({DOS_ENTRY_HI, 8'h00}, 1'b0, 1'b1);
		io_write({8'h00, PORT_CFG_LO}, 8'h03);
		for (int w = 0; w < NUM_WIN; w++)
		begin
			io_read({win_idx_t'(w), 6'd0, PORT_RDBK_LO});
			random_access(w);
		end
		finish_test("beeper and soft reset");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			error_total());
		if (error_total() == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/zx_pager_assert.sv
`timescale 1ns/1ps
`default_nettype none

module zx_pager_assert import zx_pager_pkg::*;
(
	input logic     fclk,
	input logic     reset,
	input z_bus_t   bus,
	input mem_req_t mem,
	input data_t    rd_data,
	input logic     rd_valid,
	input logic     dos,
	input logic     beep,
	input logic     cpu_reset
);

	int         fail_cnt = 0;
	int         rst_cnt;
	logic       exp_rst;
	logic       io_wr;
	logic       io_rd;
	logic       mem_acc;
	logic       m1_fetch;
	logic       soft_key;
	logic       s_lock;
	logic       s_rom48;
	logic [2:0] s_ram3;
	logic       s_pager_en;
	logic       s_cpm_n;
	logic       s_beep;
	logic       s_dos_q;
	logic       exp_dos;
	data_t      s_page [NUM_WIN];
	logic       e_valid;
	win_map_t   e_map;
	offset_t    e_off;
	logic       e_rdv;
	data_t      e_rdd;
	win_map_t   cur_map;

	assign io_wr    = bus.iorq & bus.wr;
	assign io_rd    = bus.iorq & bus.rd;
	assign mem_acc  = bus.mreq & (bus.rd | bus.wr);
	assign m1_fetch = bus.mreq & bus.rd & bus.m1;
	assign soft_key = io_wr && (bus.addr[7:0] == PORT_SRST_LO) && (bus.wdata == SRST_KEY);
	assign exp_dos  = s_dos_q | ~s_cpm_n;

	// expected mapping of one window
	function automatic win_map_t exp_map(input win_idx_t w);
		win_map_t m;
		if (s_pager_en)
		begin
			m.ram_sel = s_page[w][7];
			m.page    = s_page[w][7] ? s_page[w][5:0] : {4'd0, s_page[w][1:0]};
		end
		else
		begin
			case (w)
				2'd0:    m = {1'b0, 4'd0, exp_dos, s_rom48};
				2'd1:    m = {1'b1, 6'd5};
				2'd2:    m = {1'b1, 6'd2};
				default: m = {1'b1, 3'd0, s_ram3};
			endcase
		end
		return m;
	endfunction

	always_comb
		cur_map = exp_map(bus.addr[15:14]);

	//////////////////////////////
	// shadow of reset and ports
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset || soft_key)
			rst_cnt <= 0;
		else if (rst_cnt < 64)
			rst_cnt <= rst_cnt + 1;
	end

	assign exp_rst = reset || (rst_cnt < 64);

	always_ff @(posedge fclk)
	begin
		if (exp_rst)
		begin
			s_lock     <= 1'b0;
			s_rom48    <= 1'b0;
			s_ram3     <= 3'd0;
			s_pager_en <= 1'b0;
			s_cpm_n    <= 1'b1;
			s_beep     <= 1'b0;
			s_dos_q    <= 1'b0;
			e_valid    <= 1'b0;
			e_rdv      <= 1'b0;
			for (int i = 0; i < NUM_WIN; i++)
				s_page[i] <= '0;
		end
		else
		begin
			e_valid <= mem_acc;
			e_rdv   <= io_rd;
			if (mem_acc)
			begin
				e_map <= cur_map;
				e_off <= bus.addr[13:0];
			end
			if (io_rd)
				e_rdd <= (bus.addr[7:0] == PORT_RDBK_LO) ?
					{cur_map.ram_sel, 1'b0, cur_map.page} : 8'hFF;
			if (io_wr && (bus.addr == PORT_7FFD) && !s_lock)
			begin
				s_ram3  <= bus.wdata[2:0];
				s_rom48 <= bus.wdata[4];
				s_lock  <= bus.wdata[5];
			end
			if (io_wr && (bus.addr[7:0] == PORT_CFG_LO))
			begin
				s_pager_en <= bus.wdata[0];
				s_cpm_n    <= bus.wdata[1];
			end
			if (io_wr && (bus.addr[7:0] == PORT_PAGE_LO))
				s_page[bus.addr[15:14]] <= bus.wdata;
			if (io_wr && (bus.addr[7:0] == PORT_FE_LO))
				s_beep <= bus.wdata[4];
			// entry from 3dxx in the 48k rom, exit on any ram fetch
			if (m1_fetch)
			begin
				if ((bus.addr[15:14] == 2'd0) && !cur_map.ram_sel && s_rom48
					&& (bus.addr[15:8] == DOS_ENTRY_HI))
					s_dos_q <= 1'b1;
				else if (cur_map.ram_sel)
					s_dos_q <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_cpu_reset: assert property (@(posedge fclk) disable iff (reset) cpu_reset == exp_rst)
	else
	begin
		$error("CHECK FAILED cpu_reset exp %h got %h", $sampled(exp_rst), $sampled(cpu_reset));
		fail_cnt++;
	end

	a_mem_valid: assert property (@(posedge fclk) disable iff (reset) mem.valid == e_valid)
	else
	begin
		$error("CHECK FAILED mem.valid exp %h got %h", $sampled(e_valid), $sampled(mem.valid));
		fail_cnt++;
	end

	// rom_cs, ram_cs, page and offset in one word
	a_mem_addr: assert property (@(posedge fclk) disable iff (reset)
		e_valid |-> ({mem.rom_cs, mem.ram_cs, mem.page, mem.offset}
			== {~e_map.ram_sel, e_map.ram_sel, e_map.page, e_off}))
	else
	begin
		$error("CHECK FAILED mem exp %h got %h",
			$sampled({~e_map.ram_sel, e_map.ram_sel, e_map.page, e_off}),
			$sampled({mem.rom_cs, mem.ram_cs, mem.page, mem.offset}));
		fail_cnt++;
	end

	a_rd_valid: assert property (@(posedge fclk) disable iff (reset) rd_valid == e_rdv)
	else
	begin
		$error("CHECK FAILED rd_valid exp %h got %h", $sampled(e_rdv), $sampled(rd_valid));
		fail_cnt++;
	end

	a_rd_data: assert property (@(posedge fclk) disable iff (reset) e_rdv |-> rd_data == e_rdd)
	else
	begin
		$error("CHECK FAILED rd_data exp %h got %h", $sampled(e_rdd), $sampled(rd_data));
		fail_cnt++;
	end

	a_dos: assert property (@(posedge fclk) disable iff (reset) dos == exp_dos)
	else
	begin
		$error("CHECK FAILED dos exp %h got %h", $sampled(exp_dos), $sampled(dos));
		fail_cnt++;
	end

	a_beep: assert property (@(posedge fclk) disable iff (reset) beep == s_beep)
	else
	begin
		$error("CHECK FAILED beep exp %h got %h", $sampled(s_beep), $sampled(beep));
		fail_cnt++;
	end

endmodule

bind zx_pager_top zx_pager_assert u_zx_pager_assert (
	.fclk      (fclk),
	.reset     (reset),
	.bus       (bus),
	.mem       (mem),
	.rd_data   (rd_data),
	.rd_valid  (rd_valid),
	.dos       (dos),
	.beep      (beep),
	.cpu_reset (cpu_reset)
);

`default_nettype wire

// File: zx_pager.f
src/zx_pager_pkg.sv
src/reset_stretch.sv
src/z_ports.sv
src/window_pager.sv
src/dos_ctrl.sv
src/mem_mapper.sv
src/zx_pager_top.sv
tb/zx_pager_assert.sv
tb/tb_zx_pager.sv
